// ==== alu.sv ====
`include "rvCore_consts.svh"

module alu (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input rvCorePkg::aluOpE op,
	output logic [`XLEN-1:0] result,
	output logic zero
);
	import rvCorePkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SLT: begin
				result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			end
			SLTU: begin
				result = {{(`XLEN-1){1'b0}}, a < b};
			end
			SLL: result = a << shamt;
			SRL: result = a >> shamt;
			SRA: result = $unsigned($signed(a) >>> shamt);
			// lui
			PASSB: result = b;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== immGen.sv ====
`include "rvCore_consts.svh"

module immGen (
	input logic [`XLEN-1:0] inst,
	input rvCorePkg::immFmtE immFmt,
	output logic [`XLEN-1:0] imm
);
	import rvCorePkg::*;

	logic sign;

	assign sign = inst[31];

	always_comb begin
		case (immFmt)
			FMT_I: begin
				imm = {{20{sign}}, inst[31:20]};
			end
			FMT_S: begin
				imm = {{20{sign}}, inst[31:25], inst[11:7]};
			end
			FMT_B: begin
				// bit 0 always clear
				imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			FMT_U: begin
				imm = {inst[31:12], 12'b0};
			end
			FMT_J: begin
				imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

// ==== pcUnit.sv ====
`include "rvCore_consts.svh"

module pcUnit (
	input logic clk,
	input logic rstN,
	input rvCorePkg::ctrlS ctrl,
	input logic [`XLEN-1:0] imm,
	input logic zero,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] pcPlus4
);

	logic branchTaken;
	logic [`XLEN-1:0] pcTarget;
	logic [`XLEN-1:0] pcNext;

	// bne inverts the equality test
	assign branchTaken = ctrl.branch && (zero != ctrl.branchNe);

	assign pcPlus4 = pc + `XLEN'd4;
	assign pcTarget = pc + imm;
	assign pcNext = (ctrl.jump || branchTaken) ? pcTarget : pcPlus4;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

// ==== regFile.sv ====
`include "rvCore_consts.svh"

module regFile (
	input logic clk,
	input logic [$clog2(`REG_COUNT)-1:0] rs1,
	input logic [$clog2(`REG_COUNT)-1:0] rs2,
	input logic [$clog2(`REG_COUNT)-1:0] rd,
	input logic we,
	input logic [`XLEN-1:0] wdata,
	output logic [`XLEN-1:0] rdata1,
	output logic [`XLEN-1:0] rdata2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads as zero regardless of array contents
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rvCore.f --top-module rvCoreTb

out=$(./obj_dir/VrvCoreTb)
echo "$out"

if echo "$out" | grep -q 'All tests passed!'; then
	exit 0
fi
exit 1

// ==== rvCore.f ====
+incdir+.
rvCorePkg.sv
rvDecoder.sv
immGen.sv
regFile.sv
alu.sv
pcUnit.sv
rvCore.sv
rvCoreTb.sv

// ==== rvCore.sv ====
`include "rvCore_consts.svh"

module rvCore (
	input logic clk,
	input logic rstN,
	output logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] inst,
	output rvCorePkg::memReqS memReq,
	input logic [`XLEN-1:0] rdata
);
	import rvCorePkg::*;

	ctrlS ctrl;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] aluResult;
	logic aluZero;
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] wbData;

	rvDecoder decoder0 (
		.inst(inst),
		.rstN(rstN),
		.ctrl(ctrl)
	);

	immGen immGen0 (
		.inst(inst),
		.immFmt(ctrl.immFmt),
		.imm(imm)
	);

	regFile regFile0 (
		.clk(clk),
		.rs1(inst[19:15]),
		.rs2(inst[24:20]),
		.rd(inst[11:7]),
		.we(ctrl.regWrite),
		.wdata(wbData),
		.rdata1(rs1Data),
		.rdata2(rs2Data)
	);

	assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

	alu alu0 (
		.a(rs1Data),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	pcUnit pcUnit0 (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.imm(imm),
		.zero(aluZero),
		.pc(pc),
		.pcPlus4(pcPlus4)
	);

	// load data, then link address, then alu
	always_comb begin
		if (ctrl.memToReg) begin
			wbData = rdata;
		end else if (ctrl.linkPc) begin
			wbData = pcPlus4;
		end else begin
			wbData = aluResult;
		end
	end

	always_comb begin
		memReq.addr = aluResult;
		memReq.wdata = rs2Data;
		memReq.write = ctrl.memWrite;
		memReq.read = ctrl.memRead;
	end

endmodule

// ==== rvCorePkg.sv ====
`include "rvCore_consts.svh"

package rvCorePkg;

	// rv32i major opcodes handled by the core
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcodeE;

	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,
		AND   = 4'd2,
		OR    = 4'd3,
		XOR   = 4'd4,
		SLT   = 4'd5,
		SLTU  = 4'd6,
		SLL   = 4'd7,
		SRL   = 4'd8,
		SRA   = 4'd9,
		PASSB = 4'd10
	} aluOpE;

	// immediate encodings
	typedef enum logic [2:0] {
		FMT_I = 3'd0,
		FMT_S = 3'd1,
		FMT_B = 3'd2,
		FMT_U = 3'd3,
		FMT_J = 3'd4
	} immFmtE;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic memRead;
		logic aluSrcImm;
		logic branch;
		logic branchNe;
		logic jump;
		// write back pc+4
		logic linkPc;
		aluOpE aluOp;
		immFmtE immFmt;
	} ctrlS;

	// data port request, addr and wdata valid with write or read
	typedef struct packed {
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wdata;
		logic write;
		logic read;
	} memReqS;

endpackage

// ==== rvCoreTb.sv ====
`include "rvCore_consts.svh"

module rvCoreTb;
	import rvCorePkg::*;

	logic clk;
	logic rstN;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] inst;
	memReqS memReq;
	logic [`XLEN-1:0] rdata;

	logic [31:0] rom [0:255];
	logic [31:0] ram [0:255];
	int progLen = 0;
	int cycles = 0;
	int limit = 0;
	int errors = 0;
	int errAtStart = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int curTest = 0;
	int resetEdges = 0;
	bit resetReported = 0;
	string testName [$];
	int testEnd [$];
	logic [31:0] lcgState = 32'h589d_a856;

	// shadow architectural state
	logic [31:0] mReg [0:31];
	logic [31:0] mMem [0:255];
	logic [31:0] mPc;
	logic [31:0] haltPc;

	rvCore dut0 (
		.clk(clk),
		.rstN(rstN),
		.pc(pc),
		.inst(inst),
		.memReq(memReq),
		.rdata(rdata)
	);

	always #10 clk = ~clk;

	// memories answer combinationally
	assign inst = rom[pc[9:2]];
	assign rdata = ram[memReq.addr[9:2]];

	always @(posedge clk) begin
		if (memReq.write) begin
			ram[memReq.addr[9:2]] <= memReq.wdata;
		end
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] encS(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] encJ(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	task automatic emit(logic [31:0] word);
		rom[progLen[7:0]] = word;
		progLen++;
	endtask

	// lui/addi pair with the upper part rounded for the sign of the low part
	task automatic loadConst(int rd, logic [31:0] val);
		logic [31:0] upper;
		upper = val + 32'h800;
		emit({upper[31:12], rd[4:0], 7'h37});
		emit(encI(int'(val[11:0]), rd, 0, rd, 7'h13));
	endtask

	task automatic markTest(string name);
		testName.push_back(name);
		testEnd.push_back(progLen - 1);
	endtask

	function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes the instruction at mPc and returns the expected data request
	function automatic memReqS refStep();
		memReqS exp;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] nextPc;
		logic [4:0] rd;
		w = rom[mPc[9:2]];
		rd = w[11:7];
		a = mReg[w[19:15]];
		b = mReg[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		nextPc = mPc + 32'd4;
		exp = '0;
		case (w[6:0])
			7'h33: mReg[rd] = aluRef(w[14:12], w[30], a, b);
			7'h13: mReg[rd] = aluRef(w[14:12], w[30] && w[14:12] == 3'd5, a, immI);
			7'h37: mReg[rd] = {w[31:12], 12'b0};
			7'h03: begin
				exp.read = 1'b1;
				exp.addr = a + immI;
				mReg[rd] = mMem[exp.addr[9:2]];
			end
			7'h23: begin
				exp.write = 1'b1;
				exp.addr = a + immS;
				exp.wdata = b;
				mMem[exp.addr[9:2]] = b;
			end
			7'h63: begin
				if ((w[12] == 1'b0 && a == b) || (w[12] == 1'b1 && a != b)) begin
					nextPc = mPc + immB;
				end
			end
			7'h6f: begin
				mReg[rd] = mPc + 32'd4;
				nextPc = mPc + immJ;
			end
			default: begin
			end
		endcase
		mReg[0] = '0;
		mPc = nextPc;
		return exp;
	endfunction

	task automatic reportMismatch(string name, logic [31:0] exp, logic [31:0] act);
		$display("mismatch %s: expected %h, actual %h", name, exp, act);
		errors++;
	endtask

	task automatic checkPc(logic [`XLEN-1:0] act, logic [`XLEN-1:0] exp);
		if (act !== exp) begin
			reportMismatch("pc", exp, act);
		end
	endtask

	task automatic checkMemReq(memReqS act, memReqS exp);
		if (act.write !== exp.write) begin
			reportMismatch("memReq.write", 32'(exp.write), 32'(act.write));
		end
		if (act.read !== exp.read) begin
			reportMismatch("memReq.read", 32'(exp.read), 32'(act.read));
		end
		if ((exp.write || exp.read) && act.addr !== exp.addr) begin
			reportMismatch("memReq.addr", exp.addr, act.addr);
		end
		if (exp.write && act.wdata !== exp.wdata) begin
			reportMismatch("memReq.wdata", exp.wdata, act.wdata);
		end
	endtask

	task automatic closeTest(string name);
		testsRun++;
		if (errors == errAtStart) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: FAILED with %0d errors", name, errors - errAtStart);
		end
		errAtStart = errors;
	endtask

	task automatic finishRun();
		$display("tests run %0d, passed %0d, failed %0d, failing checks %0d",
			testsRun, testsRun - testsFailed, testsFailed, errors);
		if (errors == 0 && testsFailed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	endtask

	task automatic buildProgram();
		int storeAddr;
		int rFn [10];
		storeAddr = 32'h100;
		// store at the reset address so its fetch during reset is a memory access
		emit(encS('h0fc, 0, 0));
		// funct7 bit 5 and funct3 of each register op
		rFn = '{'h000, 'h100, 'h007, 'h006, 'h004, 'h002, 'h003, 'h001, 'h005, 'h105};
		for (int pair = 0; pair < 2; pair++) begin
			loadConst(1, lcgNext());
			loadConst(2, lcgNext());
			foreach (rFn[i]) begin
				emit(encR((rFn[i] >> 8) * 32, 2, 1, rFn[i] & 7, 3));
				emit(encS(storeAddr, 3, 0));
				storeAddr += 4;
			end
			for (int f3 = 0; f3 < 8; f3++) begin
				if (f3 == 1 || f3 == 5) begin
					emit(encI(int'(lcgNext() & 32'h1f), 1, f3, 3, 7'h13));
				end else begin
					emit(encI(int'(lcgNext() & 32'hfff), 1, f3, 3, 7'h13));
				end
				emit(encS(storeAddr, 3, 0));
				storeAddr += 4;
			end
			// srai
			emit(encI(int'(32'h400 | (lcgNext() & 32'h1f)), 1, 5, 3, 7'h13));
			emit(encS(storeAddr, 3, 0));
			storeAddr += 4;
			emit({lcgNext() & 32'hffff_f000} | 32'h1b7);
			emit(encS(storeAddr, 3, 0));
			storeAddr += 4;
		end
		markTest("alu");
		emit(encI('h100, 0, 2, 4, 7'h03));
		emit(encS('h200, 4, 0));
		emit(encI('h104, 0, 2, 5, 7'h03));
		emit(encS('h204, 5, 0));
		emit(encI(5, 0, 0, 0, 7'h13));
		emit(encS('h208, 0, 0));
		markTest("load and x0");
		emit(encI(3, 0, 0, 6, 7'h13));
		emit(encI(0, 0, 0, 7, 7'h13));
		emit(encI(1, 7, 0, 7, 7'h13));
		// backward bne taken twice and then not taken
		emit(encB(-4, 6, 7, 1));
		emit(encB(8, 6, 7, 0));
		emit(encI(1, 0, 0, 8, 7'h13));
		emit(encB(8, 0, 7, 0));
		emit(encB(8, 0, 7, 1));
		emit(encI(2, 0, 0, 8, 7'h13));
		emit(encS('h20c, 7, 0));
		markTest("branch");
		emit(encJ(12, 9));
		emit(encI(3, 0, 0, 8, 7'h13));
		emit(encI(4, 0, 0, 8, 7'h13));
		emit(encS('h210, 9, 0));
		markTest("jal");
		emit(32'h0000_007f);
		emit(32'h1234_567b);
		emit(encS('h214, 6, 0));
		markTest("unknown opcode");
		haltPc = 32'(progLen * 4);
		emit(encJ(0, 0));
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		for (int i = 0; i < 256; i++) begin
			rom[i] = 32'h0000_0013;
			ram[i] = (32'(i) << 2) * 32'h9e37_79b9 ^ 32'h5a5a_c3c3;
			mMem[i] = ram[i];
		end
		for (int i = 0; i < 32; i++) begin
			mReg[i] = '0;
		end
		mPc = `RESET_PC;
		buildProgram();
		limit = 2 * progLen + 50;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("error: timeout after %0d cycles, the program never reached its end", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	always @(posedge clk) begin
		memReqS exp;
		logic [31:0] stepPc;
		int idx;
		if (!rstN) begin
			if (resetEdges > 0) begin
				checkPc(pc, `RESET_PC);
			end
			if (memReq.write !== 1'b0 || memReq.read !== 1'b0) begin
				$display("error: memory request active during reset");
				errors++;
			end
			resetEdges++;
		end else begin
			if (!resetReported) begin
				closeTest("reset");
				resetReported = 1'b1;
			end
			stepPc = mPc;
			checkPc(pc, stepPc);
			exp = refStep();
			checkMemReq(memReq, exp);
			idx = int'(stepPc >> 2);
			if (curTest < testEnd.size() && idx == testEnd[curTest]) begin
				closeTest(testName[curTest]);
				curTest++;
			end
			if (mPc == haltPc) begin
				finishRun();
			end
		end
	end

endmodule

// ==== rvCore_consts.svh ====
`ifndef RVCORE_CONSTS_SVH
`define RVCORE_CONSTS_SVH

// data and address width
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== rvDecoder.sv ====
`include "rvCore_consts.svh"

module rvDecoder (
	input logic [`XLEN-1:0] inst,
	input logic rstN,
	output rvCorePkg::ctrlS ctrl
);
	import rvCorePkg::*;

	localparam int regIdxW = $clog2(`REG_COUNT);

	opcodeE opcode;
	logic [2:0] funct3;
	logic altFn;
	logic [regIdxW-1:0] rdIdx;
	logic rdLive;

	// funct3 to alu op, sub only exists in the register form
	function automatic aluOpE decodeAluOp(
		input logic [2:0] f3,
		input logic alt,
		input logic regForm
	);
		aluOpE op;
		case (f3)
			3'b000: op = (alt && regForm) ? SUB : ADD;
			3'b001: op = SLL;
			3'b010: op = SLT;
			3'b011: op = SLTU;
			3'b100: op = XOR;
			3'b101: op = alt ? SRA : SRL;
			3'b110: op = OR;
			default: op = AND;
		endcase
		return op;
	endfunction

	assign opcode = opcodeE'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign altFn = inst[30];
	assign rdIdx = inst[11:7];

	// no point writing x0
	assign rdLive = (rdIdx != '0);

	always_comb begin
		ctrl = '0;
		if (rstN) begin
			case (opcode)
				OP: begin
					ctrl.regWrite = rdLive;
					ctrl.aluOp = decodeAluOp(funct3, altFn, 1'b1);
				end
				OP_IMM: begin
					ctrl.regWrite = rdLive;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp = decodeAluOp(funct3, altFn, 1'b0);
					ctrl.immFmt = FMT_I;
				end
				LUI: begin
					ctrl.regWrite = rdLive;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp = PASSB;
					ctrl.immFmt = FMT_U;
				end
				LOAD: begin
					// word loads only
					if (funct3 == 3'b010) begin
						ctrl.regWrite = rdLive;
						ctrl.memToReg = 1'b1;
						ctrl.memRead = 1'b1;
						ctrl.aluSrcImm = 1'b1;
						ctrl.aluOp = ADD;
						ctrl.immFmt = FMT_I;
					end
				end
				STORE: begin
					if (funct3 == 3'b010) begin
						ctrl.memWrite = 1'b1;
						ctrl.aluSrcImm = 1'b1;
						ctrl.aluOp = ADD;
						ctrl.immFmt = FMT_S;
					end
				end
				BRANCH: begin
					// beq and bne, compare by subtract
					if (funct3[2:1] == 2'b00) begin
						ctrl.branch = 1'b1;
						ctrl.branchNe = funct3[0];
						ctrl.aluOp = SUB;
						ctrl.immFmt = FMT_B;
					end
				end
				JAL: begin
					ctrl.regWrite = rdLive;
					ctrl.jump = 1'b1;
					ctrl.linkPc = 1'b1;
					ctrl.immFmt = FMT_J;
				end
				default: begin
					ctrl = '0;
				end
			endcase
		end
	end

endmodule
